/* source/te_defines.svh */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// sized for an RV32 core, XLEN must stay a multiple of 8
// PAYLOAD_LEN must hold the longest trap packet
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`ifndef TE_DEFINES_SVH
`define TE_DEFINES_SVH

`default_nettype none

// address and trap operand widths
`define XLEN 32
`define CAUSE_LEN 5
`define PRIV_LEN 3

// branch map as kept by the tracer
`define BRANCH_COUNT_LEN 5
`define BRANCH_MAP_LEN 31
// count at which the map is full and the address tail is dropped
`define BRANCH_MAP_FULL 31

// output bus and byte count
`define PAYLOAD_LEN 80
`define P_LEN 4

`default_nettype wire

`endif

/* source/te_pkg.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// field encodings follow the RISC-V E-Trace spec
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "te_defines.svh"
`default_nettype none

package te_pkg;

    // packet format, two bits at the head of every payload
    typedef enum logic [1:0] {
        F_OPT_EXT    = 2'h0,
        F_DIFF_DELTA = 2'h1,
        F_ADDR_ONLY  = 2'h2,
        F_SYNC       = 2'h3
    } format_e;

    // format 3 subformats
    typedef enum logic [1:0] {
        SF_START   = 2'h0,
        SF_TRAP    = 2'h1,
        SF_CONTEXT = 2'h2,
        SF_SUPPORT = 2'h3
    } sync_sf_e;

    // qualification status reported in support packets
    typedef enum logic [1:0] {
        NO_CHANGE  = 2'h0,
        ENDED_REP  = 2'h1,
        TRACE_LOST = 2'h2,
        ENDED_NTR  = 2'h3
    } qual_status_e;

    // instruction trace options, passed through untouched
    typedef enum logic [2:0] {
        DELTA_ADDRESS      = 3'h0,
        FULL_ADDRESS       = 3'h1,
        IMPLICIT_EXCEPTION = 3'h2,
        SIJUMP             = 3'h3,
        IMPLICIT_RETURN    = 3'h4,
        BRANCH_PREDICTION  = 3'h5,
        JUMP_TARGET_CACHE  = 3'h6
    } ioptions_e;

    // keep bits rounded up to whole bytes, never below one byte
    function automatic logic [$clog2(`XLEN/8):0] addr_bytes_f(
        input logic [$clog2(`XLEN):0] keep_bits
    );
        logic [4:0] bytes;
        bytes = 5'((7'(keep_bits) + 7'd7) >> 3);
        if (bytes == 5'd0) begin
            return 1;
        end
        // more keep bits than the address holds
        if (bytes > 5'(`XLEN / 8)) begin
            return ($clog2(`XLEN/8) + 1)'(`XLEN / 8);
        end
        return ($clog2(`XLEN/8) + 1)'(bytes);
    endfunction

endpackage

`default_nettype wire

/* source/te_frag_if.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// payload bits above used_bits must be driven zero
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "te_defines.svh"
`default_nettype none

interface te_frag_if;

    // this packer owns the current format
    logic                    hit;
    logic [`PAYLOAD_LEN-1:0] payload;
    // bits of payload in use, LSB first
    logic [6:0]              used_bits;
    // packet carries an address reference
    logic                    anchor;

    modport src (output hit, output payload, output used_bits, output anchor);
    modport dst (input hit, input payload, input used_bits, input anchor);

endinterface

`default_nettype wire

/* source/te_sync_packer.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// format 3 only, time and context fields never emitted
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "te_defines.svh"
`default_nettype none

module te_sync_packer (
    input  te_pkg::format_e             packet_format_i,
    input  te_pkg::sync_sf_e            packet_f_sync_subformat_i,
    input  logic [`CAUSE_LEN-1:0]       lc_cause_i,
    input  logic [`XLEN-1:0]            lc_tval_i,
    input  logic                        lc_interrupt_i,
    input  logic [`CAUSE_LEN-1:0]       tc_cause_i,
    input  logic [`XLEN-1:0]            tc_tval_i,
    input  logic                        tc_interrupt_i,
    input  logic                        tc_branch_i,
    input  logic                        tc_branch_taken_i,
    input  logic [`PRIV_LEN-1:0]        tc_priv_i,
    input  logic [`XLEN-1:0]            tc_iaddr_i,
    input  logic                        lc_tc_mux_i,
    input  logic                        thaddr_i,
    input  logic [`XLEN-1:2]            tc_tvec_i,
    input  logic [`XLEN-1:0]            lc_epc_i,
    input  logic                        tc_ienable_i,
    input  logic                        encoder_mode_i,
    input  te_pkg::qual_status_e        qual_status_i,
    input  te_pkg::ioptions_e           ioptions_i,
    input  logic [$clog2(`XLEN):0]      keep_bits_i,
    te_frag_if.src                      frag_o
);

    // fixed bits ahead of the compressed address
    localparam int START_HEAD = 4 + `PRIV_LEN + 1;
    localparam int TRAP_HEAD  = 4 + 1 + `CAUSE_LEN + `PRIV_LEN + 1 + `XLEN;

    logic                       hit;
    logic                       interrupt;
    logic [`CAUSE_LEN-1:0]      ecause;
    logic [`XLEN-1:0]           tval;
    logic [`XLEN-1:0]           trap_addr;
    logic                       branch;
    logic [$clog2(`XLEN/8):0]   addr_bytes;
    logic [$clog2(`XLEN):0]     addr_bits;
    logic [`XLEN-1:0]           addr_mask;

    // trap operands from the retiring or the current instruction
    assign interrupt = lc_tc_mux_i ? tc_interrupt_i : lc_interrupt_i;
    assign ecause    = lc_tc_mux_i ? tc_cause_i : lc_cause_i;
    assign tval      = lc_tc_mux_i ? tc_tval_i : lc_tval_i;

    // handler address is word aligned, epc is taken as is
    assign trap_addr = thaddr_i ? {tc_tvec_i, 2'b00} : lc_epc_i;

    // set when the branch was not taken
    assign branch = ~(tc_branch_i & tc_branch_taken_i);

    // keep only the low bytes of the address
    assign addr_bytes = te_pkg::addr_bytes_f(keep_bits_i);
    assign addr_bits  = {addr_bytes, 3'b000};
    assign addr_mask  = {`XLEN{1'b1}} >> (`XLEN - addr_bits);

    assign hit           = (packet_format_i == te_pkg::F_SYNC);
    assign frag_o.hit    = hit;
    // start and trap reset the address reference
    assign frag_o.anchor = hit &&
                           (packet_f_sync_subformat_i == te_pkg::SF_START ||
                            packet_f_sync_subformat_i == te_pkg::SF_TRAP);

    always_comb begin
        frag_o.payload   = '0;
        frag_o.used_bits = '0;
        if (hit) begin
            case (packet_f_sync_subformat_i)
                te_pkg::SF_START: begin
                    frag_o.payload = `PAYLOAD_LEN'({tc_iaddr_i & addr_mask, branch,
                                                    tc_priv_i, packet_f_sync_subformat_i,
                                                    packet_format_i});
                    frag_o.used_bits = 7'(START_HEAD) + 7'(addr_bits);
                end
                te_pkg::SF_TRAP: begin
                    frag_o.payload = `PAYLOAD_LEN'({trap_addr & addr_mask, tval, branch,
                                                    tc_priv_i, ecause, interrupt,
                                                    packet_f_sync_subformat_i,
                                                    packet_format_i});
                    frag_o.used_bits = 7'(TRAP_HEAD) + 7'(addr_bits);
                end
                te_pkg::SF_CONTEXT: begin
                    frag_o.payload = `PAYLOAD_LEN'({tc_priv_i, packet_f_sync_subformat_i,
                                                    packet_format_i});
                    frag_o.used_bits = 7'(4 + `PRIV_LEN);
                end
                te_pkg::SF_SUPPORT: begin
                    // encoder state, no data trace fields
                    frag_o.payload = `PAYLOAD_LEN'({tc_ienable_i, encoder_mode_i,
                                                    qual_status_i, ioptions_i,
                                                    packet_f_sync_subformat_i,
                                                    packet_format_i});
                    frag_o.used_bits = 7'(4 + 3 + 2 + 1 + 1);
                end
                default: begin
                    frag_o.used_bits = '0;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

/* source/te_delta_packer.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// no notify or implicit return, irdepth is one bit
// format 0 is not emitted here
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "te_defines.svh"
`default_nettype none

module te_delta_packer (
    input  logic                          clk_i,
    input  logic                          rst_ni,
    input  te_pkg::format_e               packet_format_i,
    input  logic [`XLEN-1:0]              tc_iaddr_i,
    input  logic                          lc_updiscon_i,
    input  logic [`BRANCH_COUNT_LEN-1:0]  branches_i,
    input  logic [`BRANCH_MAP_LEN-1:0]    branch_map_i,
    input  logic [$clog2(`XLEN):0]        keep_bits_i,
    input  logic                          addr_update_i,
    te_frag_if.src                        frag_o
);

    // diff plus notify, updiscon, irreport, irdepth
    localparam int TAIL_LEN = `XLEN + 4;
    // format and branch count ahead of the map
    localparam int F1_HEAD  = 2 + `BRANCH_COUNT_LEN;

    logic                                 hit;
    logic [`XLEN-1:0]                     latest_addr_q;
    logic [`XLEN-1:0]                     diff;
    logic                                 notify;
    logic                                 updiscon;
    logic [$clog2(`XLEN/8):0]             addr_bytes;
    logic [$clog2(`XLEN):0]               addr_bits;
    logic [`XLEN-1:0]                     addr_mask;
    logic [TAIL_LEN-1:0]                  tail;
    logic [$clog2(`BRANCH_MAP_LEN+1)-1:0] map_bits;
    logic [`BRANCH_MAP_LEN-1:0]           map_mask;
    logic                                 map_full;

    // last address sent in an anchoring packet
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            latest_addr_q <= '0;
        end else if (addr_update_i) begin
            latest_addr_q <= tc_iaddr_i;
        end
    end

    // wraps modulo 2^XLEN
    assign diff = tc_iaddr_i - latest_addr_q;

    // notify mirrors the address msb, flipped on a discontinuity
    assign notify   = tc_iaddr_i[`XLEN-1];
    assign updiscon = notify ^ lc_updiscon_i;

    assign addr_bytes = te_pkg::addr_bytes_f(keep_bits_i);
    assign addr_bits  = {addr_bytes, 3'b000};
    assign addr_mask  = {`XLEN{1'b1}} >> (`XLEN - addr_bits);

    // flags sit right above the trimmed diff
    assign tail = TAIL_LEN'(diff & addr_mask) |
                  (TAIL_LEN'({{3{updiscon}}, notify}) << addr_bits);

    // map length by branch count band
    always_comb begin
        if (branches_i == 0) begin
            map_bits = 5'd0;
        end else if (branches_i == 1) begin
            map_bits = 5'd1;
        end else if (branches_i <= 9) begin
            map_bits = 5'd9;
        end else if (branches_i <= 17) begin
            map_bits = 5'd17;
        end else if (branches_i <= 25) begin
            map_bits = 5'd25;
        end else begin
            map_bits = 5'd31;
        end
    end

    assign map_mask = {`BRANCH_MAP_LEN{1'b1}} >> (`BRANCH_MAP_LEN - map_bits);
    // full map needs no address
    assign map_full = (branches_i >= `BRANCH_MAP_FULL);

    // both formats refresh the address reference
    assign hit = (packet_format_i == te_pkg::F_ADDR_ONLY) ||
                 (packet_format_i == te_pkg::F_DIFF_DELTA);
    assign frag_o.hit    = hit;
    assign frag_o.anchor = hit;

    always_comb begin
        frag_o.payload   = '0;
        frag_o.used_bits = '0;
        case (packet_format_i)
            te_pkg::F_ADDR_ONLY: begin
                frag_o.payload   = `PAYLOAD_LEN'(packet_format_i) | (`PAYLOAD_LEN'(tail) << 2);
                frag_o.used_bits = 7'(2 + 4) + 7'(addr_bits);
            end
            te_pkg::F_DIFF_DELTA: begin
                frag_o.payload   = `PAYLOAD_LEN'({branch_map_i & map_mask, branches_i,
                                                  packet_format_i});
                frag_o.used_bits = 7'(F1_HEAD) + 7'(map_bits);
                // address tail only while the map still has room
                if (!map_full) begin
                    frag_o.payload   = frag_o.payload |
                                       (`PAYLOAD_LEN'(tail) << (F1_HEAD + map_bits));
                    frag_o.used_bits = frag_o.used_bits + 7'(4) + 7'(addr_bits);
                end
            end
            default: begin
                frag_o.payload = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

/* source/te_packet_combiner.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// packers must never hit in the same cycle
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "te_defines.svh"
`default_nettype none

module te_packet_combiner (
    input  logic                     valid_i,
    te_frag_if.dst                   sync_i,
    te_frag_if.dst                   delta_i,
    output logic                     packet_valid_o,
    output logic [`PAYLOAD_LEN-1:0]  packet_payload_o,
    output logic [`P_LEN-1:0]        payload_length_o,
    output logic                     branch_map_flush_o,
    output logic                     addr_update_o
);

    logic [`PAYLOAD_LEN-1:0] payload;
    logic [6:0]              used_bits;
    logic [7:0]              used_round;
    logic                    anchor;

    // only the hitting fragment gets through
    assign payload   = ({`PAYLOAD_LEN{sync_i.hit}} & sync_i.payload) |
                       ({`PAYLOAD_LEN{delta_i.hit}} & delta_i.payload);
    assign used_bits = ({7{sync_i.hit}} & sync_i.used_bits) |
                       ({7{delta_i.hit}} & delta_i.used_bits);
    assign anchor    = (sync_i.hit & sync_i.anchor) | (delta_i.hit & delta_i.anchor);

    // round up to whole bytes, one spare bit against overflow
    assign used_round = 8'(used_bits) + 8'd7;

    // a packet every valid cycle, format 0 goes out empty
    assign packet_valid_o   = valid_i;
    assign packet_payload_o = valid_i ? payload : '0;
    assign payload_length_o = valid_i ? `P_LEN'(used_round >> 3) : '0;

    // map is read this cycle and cleared on the next
    assign branch_map_flush_o = valid_i;
    assign addr_update_o      = valid_i & anchor;

endmodule

`default_nettype wire

/* source/te_emitter_top.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// outputs are combinational from valid_i, no back-pressure
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "te_defines.svh"
`default_nettype none

module te_emitter_top (
    input  logic                          clk_i,
    input  logic                          rst_ni,
    input  logic                          valid_i,
    input  te_pkg::format_e               packet_format_i,
    input  te_pkg::sync_sf_e              packet_f_sync_subformat_i,
    // last cycle trap operands
    input  logic [`CAUSE_LEN-1:0]         lc_cause_i,
    input  logic [`XLEN-1:0]              lc_tval_i,
    input  logic                          lc_interrupt_i,
    // this cycle trap operands
    input  logic [`CAUSE_LEN-1:0]         tc_cause_i,
    input  logic [`XLEN-1:0]              tc_tval_i,
    input  logic                          tc_interrupt_i,
    input  logic                          tc_branch_i,
    input  logic                          tc_branch_taken_i,
    input  logic [`PRIV_LEN-1:0]          tc_priv_i,
    input  logic [`XLEN-1:0]              tc_iaddr_i,
    input  logic                          lc_tc_mux_i,
    input  logic                          thaddr_i,
    input  logic [`XLEN-1:2]              tc_tvec_i,
    input  logic [`XLEN-1:0]              lc_epc_i,
    // support packet fields
    input  logic                          tc_ienable_i,
    input  logic                          encoder_mode_i,
    input  te_pkg::qual_status_e          qual_status_i,
    input  te_pkg::ioptions_e             ioptions_i,
    // format 1 and 2 fields
    input  logic                          lc_updiscon_i,
    input  logic [`BRANCH_COUNT_LEN-1:0]  branches_i,
    input  logic [`BRANCH_MAP_LEN-1:0]    branch_map_i,
    input  logic [$clog2(`XLEN):0]        keep_bits_i,
    output logic                          packet_valid_o,
    output logic [`PAYLOAD_LEN-1:0]       packet_payload_o,
    output logic [`P_LEN-1:0]             payload_length_o,
    output logic                          branch_map_flush_o
);

    // address reference reload
    logic addr_update;

    te_frag_if sync_frag ();
    te_frag_if delta_frag ();

    te_sync_packer i_sync_packer (
        .packet_format_i           (packet_format_i),
        .packet_f_sync_subformat_i (packet_f_sync_subformat_i),
        .lc_cause_i                (lc_cause_i),
        .lc_tval_i                 (lc_tval_i),
        .lc_interrupt_i            (lc_interrupt_i),
        .tc_cause_i                (tc_cause_i),
        .tc_tval_i                 (tc_tval_i),
        .tc_interrupt_i            (tc_interrupt_i),
        .tc_branch_i               (tc_branch_i),
        .tc_branch_taken_i         (tc_branch_taken_i),
        .tc_priv_i                 (tc_priv_i),
        .tc_iaddr_i                (tc_iaddr_i),
        .lc_tc_mux_i               (lc_tc_mux_i),
        .thaddr_i                  (thaddr_i),
        .tc_tvec_i                 (tc_tvec_i),
        .lc_epc_i                  (lc_epc_i),
        .tc_ienable_i              (tc_ienable_i),
        .encoder_mode_i            (encoder_mode_i),
        .qual_status_i             (qual_status_i),
        .ioptions_i                (ioptions_i),
        .keep_bits_i               (keep_bits_i),
        .frag_o                    (sync_frag.src)
    );

    te_delta_packer i_delta_packer (
        .clk_i           (clk_i),
        .rst_ni          (rst_ni),
        .packet_format_i (packet_format_i),
        .tc_iaddr_i      (tc_iaddr_i),
        .lc_updiscon_i   (lc_updiscon_i),
        .branches_i      (branches_i),
        .branch_map_i    (branch_map_i),
        .keep_bits_i     (keep_bits_i),
        .addr_update_i   (addr_update),
        .frag_o          (delta_frag.src)
    );

    te_packet_combiner i_packet_combiner (
        .valid_i            (valid_i),
        .sync_i             (sync_frag.dst),
        .delta_i            (delta_frag.dst),
        .packet_valid_o     (packet_valid_o),
        .packet_payload_o   (packet_payload_o),
        .payload_length_o   (payload_length_o),
        .branch_map_flush_o (branch_map_flush_o),
        .addr_update_o      (addr_update)
    );

endmodule

`default_nettype wire

/* sim/te_emitter_tb.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// random packets from a fixed seed against a field-by-field model
// valid_i stays low through reset
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "te_defines.svh"
`default_nettype none

module te_emitter_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int CLK_PERIOD   = 100;
    localparam int RESET_CYCLES = 16;
    localparam int CYCLES       = 3000;
    localparam int SEED         = 638;
    // one and a half times the reset and test cycles
    localparam int TIMEOUT_NS   = (RESET_CYCLES + CYCLES) * CLK_PERIOD * 3 / 2;

    logic                         clk_i;
    logic                         rst_ni;
    logic                         valid_i;
    te_pkg::format_e              packet_format_i;
    te_pkg::sync_sf_e             packet_f_sync_subformat_i;
    logic [`CAUSE_LEN-1:0]        lc_cause_i;
    logic [`XLEN-1:0]             lc_tval_i;
    logic                         lc_interrupt_i;
    logic [`CAUSE_LEN-1:0]        tc_cause_i;
    logic [`XLEN-1:0]             tc_tval_i;
    logic                         tc_interrupt_i;
    logic                         tc_branch_i;
    logic                         tc_branch_taken_i;
    logic [`PRIV_LEN-1:0]         tc_priv_i;
    logic [`XLEN-1:0]             tc_iaddr_i;
    logic                         lc_tc_mux_i;
    logic                         thaddr_i;
    logic [`XLEN-1:2]             tc_tvec_i;
    logic [`XLEN-1:0]             lc_epc_i;
    logic                         tc_ienable_i;
    logic                         encoder_mode_i;
    te_pkg::qual_status_e         qual_status_i;
    te_pkg::ioptions_e            ioptions_i;
    logic                         lc_updiscon_i;
    logic [`BRANCH_COUNT_LEN-1:0] branches_i;
    logic [`BRANCH_MAP_LEN-1:0]   branch_map_i;
    logic [$clog2(`XLEN):0]       keep_bits_i;
    logic                         packet_valid_o;
    logic [`PAYLOAD_LEN-1:0]      packet_payload_o;
    logic [`P_LEN-1:0]            payload_length_o;
    logic                         branch_map_flush_o;

    // model state
    logic [`XLEN-1:0]             model_latest;
    logic                         model_anchor;
    logic [`PAYLOAD_LEN-1:0]      exp_payload;
    int                           exp_pos;
    int                           error_count;

    te_emitter_top UUT (.*);

    initial begin
        clk_i = 1'b0;
        forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
    end

    // watchdog
    initial begin
        #(TIMEOUT_NS);
        $display("watchdog expired, the simulation timed out at %0t", $time);
        $display("Simulation FAILED");
        $fatal(1, "run did not finish in time");
    end

    task automatic check_value(input string name, input logic [`PAYLOAD_LEN-1:0] actual,
                               input logic [`PAYLOAD_LEN-1:0] expected);
        if (actual !== expected) begin
            error_count = error_count + 1;
            $display("CHECK FAILED: %s actual=0x%0h expected=0x%0h at %0t",
                     name, actual, expected, $time);
            $display("Simulation FAILED");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    // append a field above the ones already placed
    task automatic put_field(input logic [`XLEN-1:0] value, input int width);
        logic [`PAYLOAD_LEN-1:0] field;
        field       = `PAYLOAD_LEN'(value);
        field       = field & ~({`PAYLOAD_LEN{1'b1}} << width);
        exp_payload = exp_payload | (field << exp_pos);
        exp_pos     = exp_pos + width;
    endtask

    // keep bits rounded up to one to four address bytes
    function automatic int address_bytes(input int keep);
        int bytes;
        bytes = (keep + 7) / 8;
        if (bytes < 1) bytes = 1;
        if (bytes > `XLEN / 8) bytes = `XLEN / 8;
        return bytes;
    endfunction

    function automatic int map_length(input int count);
        if (count == 0) return 0;
        if (count == 1) return 1;
        if (count <= 9) return 9;
        if (count <= 17) return 17;
        if (count <= 25) return 25;
        return 31;
    endfunction

    // diff and the discontinuity flags shared by formats 1 and 2
    task automatic put_address_tail(input int addr_bits);
        logic updiscon;
        updiscon = tc_iaddr_i[`XLEN-1] ^ lc_updiscon_i;
        put_field(tc_iaddr_i - model_latest, addr_bits);
        put_field(tc_iaddr_i[`XLEN-1], 1);
        put_field(updiscon, 1);
        put_field(updiscon, 1);
        put_field(updiscon, 1);
    endtask

    task automatic build_expected();
        int addr_bits;
        logic branch;
        logic [`XLEN-1:0] trap_addr;
        addr_bits    = 8 * address_bytes(int'(keep_bits_i));
        branch       = ~(tc_branch_i & tc_branch_taken_i);
        trap_addr    = thaddr_i ? {tc_tvec_i, 2'b00} : lc_epc_i;
        exp_payload  = '0;
        exp_pos      = 0;
        model_anchor = 1'b0;
        if (packet_format_i == te_pkg::F_SYNC) begin
            put_field(packet_format_i, 2);
            put_field(packet_f_sync_subformat_i, 2);
            case (packet_f_sync_subformat_i)
                te_pkg::SF_START: begin
                    put_field(tc_priv_i, `PRIV_LEN);
                    put_field(branch, 1);
                    put_field(tc_iaddr_i, addr_bits);
                    model_anchor = 1'b1;
                end
                te_pkg::SF_TRAP: begin
                    put_field(lc_tc_mux_i ? tc_interrupt_i : lc_interrupt_i, 1);
                    put_field(lc_tc_mux_i ? tc_cause_i : lc_cause_i, `CAUSE_LEN);
                    put_field(tc_priv_i, `PRIV_LEN);
                    put_field(branch, 1);
                    put_field(lc_tc_mux_i ? tc_tval_i : lc_tval_i, `XLEN);
                    put_field(trap_addr, addr_bits);
                    model_anchor = 1'b1;
                end
                te_pkg::SF_CONTEXT: begin
                    put_field(tc_priv_i, `PRIV_LEN);
                end
                default: begin
                    put_field(ioptions_i, 3);
                    put_field(qual_status_i, 2);
                    put_field(encoder_mode_i, 1);
                    put_field(tc_ienable_i, 1);
                end
            endcase
        end else if (packet_format_i == te_pkg::F_ADDR_ONLY) begin
            put_field(packet_format_i, 2);
            put_address_tail(addr_bits);
            model_anchor = 1'b1;
        end else if (packet_format_i == te_pkg::F_DIFF_DELTA) begin
            put_field(packet_format_i, 2);
            put_field(branches_i, `BRANCH_COUNT_LEN);
            put_field(branch_map_i, map_length(int'(branches_i)));
            // full map leaves the address out
            if (branches_i < `BRANCH_MAP_FULL) begin
                put_address_tail(addr_bits);
            end
            model_anchor = 1'b1;
        end
        model_anchor = model_anchor & valid_i;
    endtask

    task automatic check_outputs();
        build_expected();
        check_value("packet_valid_o", packet_valid_o, valid_i);
        check_value("branch_map_flush_o", branch_map_flush_o, valid_i);
        // idle cycles drive zero everywhere
        if (valid_i) begin
            check_value("packet_payload_o", packet_payload_o, exp_payload);
            check_value("payload_length_o", payload_length_o, (exp_pos + 7) / 8);
        end else begin
            check_value("packet_payload_o", packet_payload_o, '0);
            check_value("payload_length_o", payload_length_o, '0);
        end
    endtask

    task automatic clear_inputs();
        valid_i                   = 1'b0;
        packet_format_i           = te_pkg::F_OPT_EXT;
        packet_f_sync_subformat_i = te_pkg::SF_START;
        lc_cause_i                = '0;
        lc_tval_i                 = '0;
        lc_interrupt_i            = 1'b0;
        tc_cause_i                = '0;
        tc_tval_i                 = '0;
        tc_interrupt_i            = 1'b0;
        tc_branch_i               = 1'b0;
        tc_branch_taken_i         = 1'b0;
        tc_priv_i                 = '0;
        tc_iaddr_i                = '0;
        lc_tc_mux_i               = 1'b0;
        thaddr_i                  = 1'b0;
        tc_tvec_i                 = '0;
        lc_epc_i                  = '0;
        tc_ienable_i              = 1'b0;
        encoder_mode_i            = 1'b0;
        qual_status_i             = te_pkg::NO_CHANGE;
        ioptions_i                = te_pkg::DELTA_ADDRESS;
        lc_updiscon_i             = 1'b0;
        branches_i                = '0;
        branch_map_i              = '0;
        keep_bits_i               = 6'd32;
    endtask

    task automatic drive_random();
        valid_i                   <= ($urandom % 4) != 0;
        packet_format_i           <= te_pkg::format_e'($urandom % 4);
        packet_f_sync_subformat_i <= te_pkg::sync_sf_e'($urandom % 4);
        lc_cause_i                <= `CAUSE_LEN'($urandom);
        lc_tval_i                 <= $urandom;
        lc_interrupt_i            <= 1'($urandom);
        tc_cause_i                <= `CAUSE_LEN'($urandom);
        tc_tval_i                 <= $urandom;
        tc_interrupt_i            <= 1'($urandom);
        tc_branch_i               <= 1'($urandom);
        tc_branch_taken_i         <= 1'($urandom);
        tc_priv_i                 <= `PRIV_LEN'($urandom);
        tc_iaddr_i                <= $urandom;
        lc_tc_mux_i               <= 1'($urandom);
        thaddr_i                  <= 1'($urandom);
        tc_tvec_i                 <= 30'($urandom);
        lc_epc_i                  <= $urandom;
        tc_ienable_i              <= 1'($urandom);
        encoder_mode_i            <= 1'($urandom);
        qual_status_i             <= te_pkg::qual_status_e'($urandom % 4);
        ioptions_i                <= te_pkg::ioptions_e'($urandom % 7);
        lc_updiscon_i             <= 1'($urandom);
        // full map about a quarter of the time
        branches_i                <= (($urandom % 4) == 0) ? 5'(`BRANCH_MAP_FULL) : 5'($urandom);
        branch_map_i              <= `BRANCH_MAP_LEN'($urandom);
        keep_bits_i               <= 6'(($urandom % `XLEN) + 1);
    endtask

    initial begin
        void'($urandom(SEED));
        error_count  = 0;
        model_latest = '0;
        model_anchor = 1'b0;
        clear_inputs();
        rst_ni = 1'b0;
        repeat (RESET_CYCLES) begin
            @(posedge clk_i);
            @(negedge clk_i);
            check_outputs();
        end
        for (int i = 0; i < CYCLES; i++) begin
            @(posedge clk_i);
            // same edge loads the DUT register from the old inputs
            if (model_anchor) begin
                model_latest = tc_iaddr_i;
            end
            rst_ni <= 1'b1;
            drive_random();
            @(negedge clk_i);
            check_outputs();
        end
        @(posedge clk_i);
        if (error_count == 0) begin
            $display("Simulation PASSED");
            $finish;
        end else begin
            $display("Simulation FAILED");
            $fatal(1, "%0d checks did not match", error_count);
        end
    end

endmodule

`default_nettype wire

/* te_emitter.f */
+incdir+source
source/te_pkg.sv
source/te_frag_if.sv
source/te_sync_packer.sv
source/te_delta_packer.sv
source/te_packet_combiner.sv
source/te_emitter_top.sv
sim/te_emitter_tb.sv

/* Bender.yml */
package:
  name: te_emitter

sources:
  - include_dirs:
      - source
    files:
      - source/te_pkg.sv
      - source/te_frag_if.sv
      - source/te_sync_packer.sv
      - source/te_delta_packer.sv
      - source/te_packet_combiner.sv
      - source/te_emitter_top.sv

  - target: test
    include_dirs:
      - source
    files:
      - sim/te_emitter_tb.sv
